/* Bender.yml */
package:
  name: blob_tracker

sources:
  - include_dirs:
      - design
    files:
      - design/tracker_pkg.sv
      - design/pixelGrader.sv
      - design/rasterCounter.sv
      - design/tileAccumulator.sv
      - design/peakSelector.sv
      - design/trackerFsm.sv
      - design/blobTracker.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/tb_blobTracker.sv

/* bench/tb_blobTracker.sv */
`include "tracker_defines.svh"

module tb_blobTracker;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int numFrames   = 15;
  localparam int framePixels = `FRAME_W * `FRAME_H;
  localparam int cycleLimit  = numFrames * framePixels * 4 + 200;
  localparam int reportDelay = 4;

  logic                  i_clk;
  logic                  i_rst_n;
  tracker_pkg::rgb_t     i_rgb;
  logic                  i_pixelVal;
  tracker_pkg::tileCol_t o_pointH;
  tracker_pkg::tileRow_t o_pointV;
  logic                  o_found;
  logic                  o_valid;

  logic [107:0]          stimMem [numFrames];
  int                    cycleCount = 0;
  int                    valueErrors = 0;
  int                    protocolErrors = 0;
  int                    stimErrors = 0;
  int                    reportCount = 0;
  int                    heldCol = 0;
  int                    heldRow = 0;

  // frames whose last pixel went out and whose report is still due
  int                    pendFrame [$];
  int                    pendStrobe [$];
  tracker_pkg::tileCol_t pendCol [$];
  tracker_pkg::tileRow_t pendRow [$];
  logic                  pendFound [$];

  blobTracker uut (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rgb      (i_rgb),
    .i_pixelVal (i_pixelVal),
    .o_pointH   (o_pointH),
    .o_pointV   (o_pointV),
    .o_found    (o_found),
    .o_valid    (o_valid)
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("test failed");
      $finish;
    end
  end

  // ===========================================================================
  // reference model
  // ===========================================================================

  // one grade step per 64 of the weaker blue margin
  function automatic int gradeOfColor(input logic [23:0] color);
    int red;
    int green;
    int blue;
    int marginR;
    int marginG;
    int margin;
    red     = color[23:16];
    green   = color[15:8];
    blue    = color[7:0];
    marginR = (blue > red) ? blue - red : 0;
    marginG = (blue > green) ? blue - green : 0;
    margin  = (marginR < marginG) ? marginR : marginG;
    return margin / 64;
  endfunction

  // ===========================================================================
  // pixel driving
  // ===========================================================================

  task automatic idleCycle();
    logic [31:0] junk;
    junk = $urandom;
    @(posedge i_clk);
    #2;
    i_pixelVal = 1'b0;
    i_rgb      = junk[23:0];
  endtask

  task automatic drivePixel(input logic [23:0] color);
    @(posedge i_clk);
    #2;
    i_pixelVal = 1'b1;
    i_rgb      = color;
  endtask

  task automatic runFrame(input int idx);
    logic [107:0] rec;
    logic [23:0]  bgColor;
    logic [23:0]  tgtColor [2];
    logic [23:0]  color;
    int           nTargets;
    int           tgtCol [2];
    int           tgtRow [2];
    int           gapMode;
    int           sums [`TILES_V][`TILES_H];
    int           bestSum;
    int           bestCol;
    int           bestRow;
    int           found;
    int           idle;
    rec         = stimMem[idx];
    bgColor     = rec[107:84];
    nTargets    = rec[83:80];
    tgtCol[0]   = rec[79:76];
    tgtRow[0]   = rec[75:72];
    tgtColor[0] = rec[71:48];
    tgtCol[1]   = rec[47:44];
    tgtRow[1]   = rec[43:40];
    tgtColor[1] = rec[39:16];
    gapMode     = rec[15:12];

    // every tile is painted in a single color, so its sum is area times grade
    for (int ty = 0; ty < `TILES_V; ty++) begin
      for (int tx = 0; tx < `TILES_H; tx++) begin
        sums[ty][tx] = `TILE_W * `TILE_H * gradeOfColor(bgColor);
      end
    end
    for (int t = 0; t < nTargets; t++) begin
      sums[tgtRow[t]][tgtCol[t]] = `TILE_W * `TILE_H * gradeOfColor(tgtColor[t]);
    end

    // strict compare in raster order keeps the first of equal tiles
    bestSum = 0;
    bestCol = 0;
    bestRow = 0;
    for (int ty = 0; ty < `TILES_V; ty++) begin
      for (int tx = 0; tx < `TILES_H; tx++) begin
        if (sums[ty][tx] > bestSum) begin
          bestSum = sums[ty][tx];
          bestCol = tx;
          bestRow = ty;
        end
      end
    end
    found = (bestSum >= `MIN_SUM);
    if (found) begin
      heldCol = bestCol;
      heldRow = bestRow;
    end

    assert (found == rec[3:0] && heldCol == rec[11:8] && heldRow == rec[7:4]) else begin
      stimErrors++;
      $display("stimulus line %0d disagrees with the model: file %0d,%0d,%0d model %0d,%0d,%0d",
               idx, rec[11:8], rec[7:4], rec[3:0], heldCol, heldRow, found);
    end

    for (int y = 0; y < `FRAME_H; y++) begin
      for (int x = 0; x < `FRAME_W; x++) begin
        color = bgColor;
        for (int t = 0; t < nTargets; t++) begin
          if (x / `TILE_W == tgtCol[t] && y / `TILE_H == tgtRow[t]) begin
            color = tgtColor[t];
          end
        end
        if (gapMode != 0) begin
          idle = $urandom_range(0, 3);
          repeat (idle) idleCycle();
        end
        drivePixel(color);
      end
    end

    pendFrame.push_back(idx);
    pendStrobe.push_back(cycleCount);
    pendCol.push_back(tracker_pkg::tileCol_t'(heldCol));
    pendRow.push_back(tracker_pkg::tileRow_t'(heldRow));
    pendFound.push_back(found[0]);
  endtask

  // ===========================================================================
  // output monitor
  // ===========================================================================

  task automatic checkReport();
    int                    frameIdx;
    int                    strobeCycle;
    tracker_pkg::tileCol_t expCol;
    tracker_pkg::tileRow_t expRow;
    logic                  expFound;
    frameIdx    = pendFrame.pop_front();
    strobeCycle = pendStrobe.pop_front();
    expCol      = pendCol.pop_front();
    expRow      = pendRow.pop_front();
    expFound    = pendFound.pop_front();
    reportCount++;
    assert (cycleCount - strobeCycle <= reportDelay) else begin
      protocolErrors++;
      $display("frame %0d was reported %0d cycles after its last pixel",
               frameIdx, cycleCount - strobeCycle);
    end
    assert (o_found === expFound) else begin
      valueErrors++;
      $display("[ERROR] frame %0d o_found: got 0x%0h expected 0x%0h", frameIdx, o_found, expFound);
    end
    assert (o_pointH === expCol) else begin
      valueErrors++;
      $display("[ERROR] frame %0d o_pointH: got 0x%0h expected 0x%0h", frameIdx, o_pointH, expCol);
    end
    assert (o_pointV === expRow) else begin
      valueErrors++;
      $display("[ERROR] frame %0d o_pointV: got 0x%0h expected 0x%0h", frameIdx, o_pointV, expRow);
    end
  endtask

  always @(negedge i_clk) begin
    if (i_rst_n) begin
      if (o_valid) begin
        assert (pendFrame.size() != 0) else begin
          protocolErrors++;
          $display("o_valid pulsed at cycle %0d with no frame awaiting a report", cycleCount);
        end
        if (pendFrame.size() != 0) begin
          checkReport();
        end
      end else if (pendFrame.size() != 0) begin
        assert (cycleCount - pendStrobe[0] <= reportDelay) else begin
          protocolErrors++;
          $display("frame %0d got no report within %0d cycles of its last pixel",
                   pendFrame[0], reportDelay);
          void'(pendFrame.pop_front());
          void'(pendStrobe.pop_front());
          void'(pendCol.pop_front());
          void'(pendRow.pop_front());
          void'(pendFound.pop_front());
        end
      end
      // outputs stay at their reset values until the first report
      if (reportCount == 0 && !o_valid) begin
        assert (o_found === 1'b0) else begin
          valueErrors++;
          $display("[ERROR] o_found before first report: got 0x%0h expected 0x0", o_found);
        end
        assert (o_pointH === '0 && o_pointV === '0) else begin
          valueErrors++;
          $display("[ERROR] o_pointH/o_pointV before first report: got 0x%0h/0x%0h expected 0x0",
                   o_pointH, o_pointV);
        end
      end
    end
  end

  // ===========================================================================
  // main sequence
  // ===========================================================================

  initial begin
    void'($urandom(32'h3bf41b10));
    i_rst_n    = 1'b0;
    i_rgb      = '0;
    i_pixelVal = 1'b0;
    $readmemh("bench/tracker_stim.txt", stimMem);
    assert (!$isunknown(stimMem[numFrames-1])) else begin
      stimErrors++;
      $display("stimulus file is missing or has fewer than %0d frames", numFrames);
    end

    repeat (8) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    repeat (6) @(posedge i_clk);

    for (int f = 0; f < numFrames; f++) begin
      runFrame(f);
    end
    idleCycle();

    while (pendFrame.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (10) @(posedge i_clk);

    assert (reportCount == numFrames) else begin
      protocolErrors++;
      $display("saw %0d reports for %0d frames", reportCount, numFrames);
    end

    $display("errors: value %0d, protocol %0d, stimulus %0d",
             valueErrors, protocolErrors, stimErrors);
    if (valueErrors + protocolErrors + stimErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* bench/tracker_stim.txt */
// bg_ntgt_col0_row0_rgb0_col1_row1_rgb1_gap_expCol_expRow_expFound, all hex
// colors are rrggbb, gap 1 adds 0 to 3 random idle cycles before each pixel
// single target, then frames that must not count as found
808080_1_3_2_0000ff_0_0_000000_0_3_2_1
808080_0_0_0_000000_0_0_000000_0_3_2_0
30306f_0_0_0_000000_0_0_000000_0_3_2_0
808080_1_5_4_00ffff_0_0_000000_0_3_2_0
808080_1_1_1_ffff00_0_0_000000_0_3_2_0
// two targets, stronger one and ties in raster order
808080_2_6_0_2020c0_2_5_0000ff_0_2_5_1
808080_2_7_1_0000ff_0_3_0000ff_0_7_1_1
808080_2_6_4_2020c0_1_4_2020c0_0_1_4_1
// random idle gaps
808080_1_4_3_0000ff_0_0_000000_1_4_3_1
808080_1_0_5_303070_0_0_000000_1_0_5_1
808080_0_0_0_000000_0_0_000000_1_0_5_0
// slightly blue background everywhere
303070_1_5_1_2020c0_0_0_000000_0_5_1_1
303070_0_0_0_000000_0_0_000000_0_0_0_1
// back to back, targets in different tile rows
808080_1_7_5_0000ff_0_0_000000_0_7_5_1
808080_1_2_0_0000ff_0_0_000000_0_2_0_1

/* design/blobTracker.sv */
`include "tracker_defines.svh"

module blobTracker (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  tracker_pkg::rgb_t     i_rgb,
  input  logic                  i_pixelVal,
  output tracker_pkg::tileCol_t o_pointH,
  output tracker_pkg::tileRow_t o_pointV,
  output logic                  o_found,
  output logic                  o_valid
);

  tracker_pkg::grade_t   grade;
  logic                  gradeVal;
  tracker_pkg::tileCol_t tileCol;
  tracker_pkg::tileRow_t tileRow;
  logic                  rowDone;
  logic                  frameDone;
  tracker_pkg::tileSum_t tileSums [`TILES_H];
  tracker_pkg::tileCol_t bestCol;
  tracker_pkg::tileRow_t bestRow;
  tracker_pkg::tileSum_t bestSum;
  logic                  selClear;

  // ===========================================================================
  // pixel front end
  // ===========================================================================

  pixelGrader uGrader (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rgb      (i_rgb),
    .i_pixelVal (i_pixelVal),
    .o_grade    (grade),
    .o_gradeVal (gradeVal)
  );

  rasterCounter uCounter (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_gradeVal  (gradeVal),
    .o_tileCol   (tileCol),
    .o_tileRow   (tileRow),
    .o_rowDone   (rowDone),
    .o_frameDone (frameDone)
  );

  // one accumulator per tile column of the current tile row
  for (genvar k = 0; k < `TILES_H; k++) begin : gAcc
    tileAccumulator uAcc (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_grade   (grade),
      .i_add     (gradeVal && (tileCol == tracker_pkg::tileCol_t'(k))),
      .i_restart (rowDone),
      .o_sum     (tileSums[k])
    );
  end

  // ===========================================================================
  // peak search and report
  // ===========================================================================

  peakSelector uSelector (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_sums    (tileSums),
    .i_rowDone (rowDone),
    .i_tileRow (tileRow),
    .i_clear   (selClear),
    .o_bestCol (bestCol),
    .o_bestRow (bestRow),
    .o_bestSum (bestSum)
  );

  trackerFsm uFsm (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_frameDone (frameDone),
    .i_bestCol   (bestCol),
    .i_bestRow   (bestRow),
    .i_bestSum   (bestSum),
    .o_selClear  (selClear),
    .o_pointH    (o_pointH),
    .o_pointV    (o_pointV),
    .o_found     (o_found),
    .o_valid     (o_valid)
  );

endmodule

/* design/peakSelector.sv */
`include "tracker_defines.svh"

module peakSelector (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  tracker_pkg::tileSum_t i_sums [`TILES_H],
  input  logic                  i_rowDone,
  input  tracker_pkg::tileRow_t i_tileRow,
  input  logic                  i_clear,
  output tracker_pkg::tileCol_t o_bestCol,
  output tracker_pkg::tileRow_t o_bestRow,
  output tracker_pkg::tileSum_t o_bestSum
);

  tracker_pkg::tileCol_t bestColQ;
  tracker_pkg::tileRow_t bestRowQ;
  tracker_pkg::tileSum_t bestSumQ;
  tracker_pkg::tileCol_t candCol;
  tracker_pkg::tileSum_t candSum;
  logic                  candHit;

  // ===========================================================================
  // scan of the finished row
  // ===========================================================================

  // strict compare keeps ties with the lower column
  always_comb begin
    candCol = bestColQ;
    candSum = bestSumQ;
    candHit = 1'b0;
    for (int k = 0; k < `TILES_H; k++) begin
      if (i_sums[k] > candSum) begin
        candCol = tracker_pkg::tileCol_t'(k);
        candSum = i_sums[k];
        candHit = 1'b1;
      end
    end
  end

  // ===========================================================================
  // running frame maximum
  // ===========================================================================

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bestColQ <= '0;
      bestRowQ <= '0;
      bestSumQ <= '0;
    end else if (i_clear) begin
      bestSumQ <= '0;
    end else if (i_rowDone && candHit) begin
      // earlier rows win ties and the stored row is the finished one
      bestColQ <= candCol;
      bestRowQ <= i_tileRow;
      bestSumQ <= candSum;
    end
  end

  assign o_bestCol = bestColQ;
  assign o_bestRow = bestRowQ;
  assign o_bestSum = bestSumQ;

endmodule

/* design/pixelGrader.sv */
`include "tracker_defines.svh"

module pixelGrader (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  tracker_pkg::rgb_t   i_rgb,
  input  logic                i_pixelVal,
  output tracker_pkg::grade_t o_grade,
  output logic                o_gradeVal
);

  logic [7:0]          excessBR;
  logic [7:0]          excessBG;
  logic [7:0]          excessMin;
  tracker_pkg::grade_t gradeQ;
  logic                gradeValQ;

  // blue excess over each other channel, floored at zero
  assign excessBR = (i_rgb.blue > i_rgb.red) ? i_rgb.blue - i_rgb.red : 8'd0;
  assign excessBG = (i_rgb.blue > i_rgb.green) ? i_rgb.blue - i_rgb.green : 8'd0;

  // a pixel is only as blue as its weaker margin
  assign excessMin = (excessBR < excessBG) ? excessBR : excessBG;

  // grade register holds between pixels
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      gradeQ <= '0;
    end else if (i_pixelVal) begin
      gradeQ <= excessMin[`GRADE_MSB:`GRADE_MSB-1];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      gradeValQ <= 1'b0;
    end else begin
      gradeValQ <= i_pixelVal;
    end
  end

  assign o_grade    = gradeQ;
  assign o_gradeVal = gradeValQ;

endmodule

/* design/rasterCounter.sv */
`include "tracker_defines.svh"

module rasterCounter (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_gradeVal,
  output tracker_pkg::tileCol_t o_tileCol,
  output tracker_pkg::tileRow_t o_tileRow,
  output logic                  o_rowDone,
  output logic                  o_frameDone
);

  tracker_pkg::hPos_t    hPos;
  tracker_pkg::vPos_t    vPos;
  tracker_pkg::tileRow_t tileRowQ;
  logic                  lastPixelOfLine;
  logic                  lastLineOfTileRow;
  logic                  lastLineOfFrame;
  logic                  rowDoneQ;
  logic                  frameDoneQ;

  assign lastPixelOfLine   = (hPos == tracker_pkg::hPos_t'(`FRAME_W - 1));
  assign lastLineOfTileRow = ((vPos % `TILE_H) == (`TILE_H - 1));
  assign lastLineOfFrame   = (vPos == tracker_pkg::vPos_t'(`FRAME_H - 1));

  // position of the pixel whose grade is presented now
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hPos <= '0;
      vPos <= '0;
    end else if (i_gradeVal) begin
      if (lastPixelOfLine) begin
        hPos <= '0;
        vPos <= lastLineOfFrame ? '0 : vPos + 1'b1;
      end else begin
        hPos <= hPos + 1'b1;
      end
    end
  end

  // end-of-row and end-of-frame pulses one cycle after the last grade
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rowDoneQ   <= 1'b0;
      frameDoneQ <= 1'b0;
    end else begin
      rowDoneQ   <= i_gradeVal && lastPixelOfLine && lastLineOfTileRow;
      frameDoneQ <= i_gradeVal && lastPixelOfLine && lastLineOfFrame;
    end
  end

  // tile row advances only after rowDone, so the selector
  // still sees the finished row during the pulse
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      tileRowQ <= '0;
    end else if (rowDoneQ) begin
      tileRowQ <= frameDoneQ ? '0 : tileRowQ + 1'b1;
    end
  end

  assign o_tileCol   = tracker_pkg::tileCol_t'(hPos / `TILE_W);
  assign o_tileRow   = tileRowQ;
  assign o_rowDone   = rowDoneQ;
  assign o_frameDone = frameDoneQ;

  // frame end always closes a tile row too
  assert property (@(posedge i_clk) disable iff (!i_rst_n) frameDoneQ |-> rowDoneQ)
    else $error("frameDone without rowDone");

  assert property (@(posedge i_clk) disable iff (!i_rst_n) rowDoneQ |=> !rowDoneQ)
    else $error("rowDone longer than one cycle");

endmodule

/* design/tileAccumulator.sv */
`include "tracker_defines.svh"

module tileAccumulator (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  tracker_pkg::grade_t   i_grade,
  input  logic                  i_add,
  input  logic                  i_restart,
  output tracker_pkg::tileSum_t o_sum
);

  tracker_pkg::tileSum_t sumQ;

  // restart may coincide with the first pixel of the next row
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sumQ <= '0;
    end else if (i_restart) begin
      sumQ <= i_add ? tracker_pkg::tileSum_t'(i_grade) : '0;
    end else if (i_add) begin
      sumQ <= sumQ + tracker_pkg::tileSum_t'(i_grade);
    end
  end

  assign o_sum = sumQ;

  // restart cadence from the counter keeps one tile inside the sum range
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_add && !i_restart) |-> ((sumQ + i_grade) <= `TILE_MAX_SUM))
    else $error("tile sum exceeds %0d", `TILE_MAX_SUM);

endmodule

/* design/trackerFsm.sv */
`include "tracker_defines.svh"

module trackerFsm (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_frameDone,
  input  tracker_pkg::tileCol_t i_bestCol,
  input  tracker_pkg::tileRow_t i_bestRow,
  input  tracker_pkg::tileSum_t i_bestSum,
  output logic                  o_selClear,
  output tracker_pkg::tileCol_t o_pointH,
  output tracker_pkg::tileRow_t o_pointV,
  output logic                  o_found,
  output logic                  o_valid
);

  typedef enum logic [1:0] {
    ST_RESET,
    ST_SCAN,
    ST_REPORT
  } state_t;

  state_t                state;
  state_t                stateNext;
  logic                  bestFound;
  tracker_pkg::tileCol_t pointHQ;
  tracker_pkg::tileRow_t pointVQ;
  logic                  foundQ;
  logic                  validQ;

  assign bestFound = (i_bestSum >= `MIN_SUM);

  always_comb begin
    stateNext = state;
    case (state)
      ST_RESET:  stateNext = ST_SCAN;
      ST_SCAN:   stateNext = i_frameDone ? ST_REPORT : ST_SCAN;
      ST_REPORT: stateNext = ST_SCAN;
      default:   stateNext = ST_RESET;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_RESET;
    end else begin
      state <= stateNext;
    end
  end

  // selector restarts after reset and after every report
  assign o_selClear = (state == ST_RESET) || (state == ST_REPORT);

  // point moves only when a target was found and holds otherwise
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pointHQ <= '0;
      pointVQ <= '0;
      foundQ  <= 1'b0;
      validQ  <= 1'b0;
    end else begin
      validQ <= (state == ST_REPORT);
      if (state == ST_REPORT) begin
        foundQ <= bestFound;
        if (bestFound) begin
          pointHQ <= i_bestCol;
          pointVQ <= i_bestRow;
        end
      end
    end
  end

  assign o_pointH = pointHQ;
  assign o_pointV = pointVQ;
  assign o_found  = foundQ;
  assign o_valid  = validQ;

  assert property (@(posedge i_clk) disable iff (!i_rst_n) validQ |=> !validQ)
    else $error("o_valid high on two cycles in a row");

endmodule

/* design/tracker_defines.svh */
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// ===========================================================================
// frame geometry
// ===========================================================================

// pixels per line
`define FRAME_W 64
// lines per frame
`define FRAME_H 48

// ===========================================================================
// tile grid
// ===========================================================================

`define TILE_W 8
`define TILE_H 8

// tiles across and down the frame
`define TILES_H 8
`define TILES_V 6

// largest possible tile sum with every pixel at grade 3
`define TILE_MAX_SUM (`TILE_W * `TILE_H * 3)

// ===========================================================================
// grading and detection
// ===========================================================================

// top bit of the two-bit slice of the blue excess
`define GRADE_MSB 7

// best tile sum needed to report a target as found
`define MIN_SUM 16

`endif

/* design/tracker_pkg.sv */
`include "tracker_defines.svh"

package tracker_pkg;

  // packed video pixel, red in the top byte
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // blueness grade of one pixel
  typedef logic [1:0] grade_t;

  // pixel position inside the frame
  typedef logic [$clog2(`FRAME_W)-1:0] hPos_t;
  typedef logic [$clog2(`FRAME_H)-1:0] vPos_t;

  // tile indices on the fixed grid
  typedef logic [$clog2(`TILES_H)-1:0] tileCol_t;
  typedef logic [$clog2(`TILES_V)-1:0] tileRow_t;

  // grade sum of one tile, up to 192
  typedef logic [7:0] tileSum_t;

endpackage

/* flist.f */
+incdir+design
design/tracker_pkg.sv
design/pixelGrader.sv
design/rasterCounter.sv
design/tileAccumulator.sv
design/peakSelector.sv
design/trackerFsm.sv
design/blobTracker.sv
bench/tb_blobTracker.sv
